/* ft_bridge.f */
ft_bridge_pkg.sv
ppfifo.sv
ft_rx_ctrl.sv
ft_tx_ctrl.sv
ft_fifo_interface.sv
ft_chip_model.sv
ft_bridge_assertions.sv
ft_bridge_tb.sv

/* ft_bridge_tb.sv */
// testbench top for the FT245 bridge
// random host bursts and user transmit banks run at the same time,
// both byte streams are checked against scoreboards
`timescale 1ns/1ps
`default_nettype none

module ft_bridge_tb
  import ft_bridge_pkg::*;
();

  logic                   ftdi_clk;
  logic                   rst;
  wire  [7:0]             ftdi_data;
  logic                   ftdi_rxf_n;
  logic                   ftdi_txe_n;
  logic                   ftdi_oe_n, ftdi_rd_n, ftdi_wr_n;
  logic                   in_fifo_read, in_fifo_activate, in_fifo_ready;
  logic [COUNT_WIDTH-1:0] in_fifo_count;
  rx_word_t               in_fifo_data;
  logic                   out_fifo_write, out_fifo_starved;
  logic [1:0]             out_fifo_activate, out_fifo_ready;
  logic [7:0]             out_fifo_data;

  integer     seed = 32'hba5b;
  int         errors = 0;
  int         limit_cycles = 0;
  int         tx_idx = 0;
  rx_word_t   exp_rx [$];
  logic [7:0] exp_tx [$];
  int         tx_lens [$];

  ft_fifo_interface i_dut (.*);
  ft_chip_model u_chip (.*);

  initial begin
    ftdi_clk = 1'b0;
    forever #2 ftdi_clk = ~ftdi_clk;
  end

  // chip has no room about one cycle in four
  always @(posedge ftdi_clk) begin
    #1;
    ftdi_txe_n = rst || (($random(seed) & 3) == 0);
  end

  task automatic step_cycle();
    @(posedge ftdi_clk);
    #1;
  endtask

  task automatic check_word(input rx_word_t got);
    rx_word_t exp;
    exp = exp_rx.pop_front();
    assert (got == exp) else begin
      $display("FAIL %0t: received sof/data %b/%h, expected %b/%h", $time,
               got.sof, got.data, exp.sof, exp.data);
      errors++;
    end
  endtask

  task automatic drain_bank();
    int n;
    in_fifo_activate = 1'b1;
    step_cycle();
    n = in_fifo_count;
    assert (n > 0 && n <= BANK_DEPTH && n <= exp_rx.size()) else begin
      $display("FAIL %0t: receive bank count %0d out of range", $time, n);
      errors++;
    end
    repeat (n) begin
      check_word(in_fifo_data);
      in_fifo_read = 1'b1;
      step_cycle();
    end
    in_fifo_read     = 1'b0;
    in_fifo_activate = 1'b0;
    step_cycle();
  endtask

  task automatic fill_bank(input int len);
    int bank;
    bank = out_fifo_ready[0] ? 0 : 1;
    out_fifo_activate[bank] = 1'b1;
    repeat (len) begin
      out_fifo_data  = exp_tx[tx_idx];
      out_fifo_write = 1'b1;
      tx_idx++;
      step_cycle();
    end
    out_fifo_write    = 1'b0;
    out_fifo_activate = 2'b00;
    step_cycle();
  endtask

  initial begin
    rx_word_t w;
    int       len;
    int       left;
    rst               = 1'b1;
    ftdi_txe_n        = 1'b1;
    in_fifo_read      = 1'b0;
    in_fifo_activate  = 1'b0;
    out_fifo_write    = 1'b0;
    out_fifo_activate = 2'b00;
    out_fifo_data     = 8'h00;
    // 8 host bursts, many longer than one bank
    for (int b = 0; b < 8; b++) begin
      len = 1 + ($unsigned($random(seed)) % 40);
      u_chip.burst_q.push_back(len);
      for (int i = 0; i < len; i++) begin
        w.sof  = (i == 0);
        w.data = 8'($random(seed));
        u_chip.host_q.push_back(w.data);
        exp_rx.push_back(w);
      end
    end
    // 120 user bytes cut into banks of random length
    for (int i = 0; i < 120; i++) begin
      exp_tx.push_back(8'($random(seed)));
    end
    left = 120;
    while (left > 0) begin
      len = 1 + ($unsigned($random(seed)) % BANK_DEPTH);
      len = (len > left) ? left : len;
      tx_lens.push_back(len);
      left -= len;
    end
    limit_cycles = 40 * (exp_rx.size() + exp_tx.size()) + 2000;

    repeat (5) @(posedge ftdi_clk);
    #1;
    rst = 1'b0;
    // first cycle out of reset stays idle on the user side
    step_cycle();
    fork
      while (exp_rx.size() > 0) begin
        if (in_fifo_ready) drain_bank();
        else step_cycle();
      end
      while (tx_lens.size() > 0) begin
        if (out_fifo_ready != 2'b00) fill_bank(tx_lens.pop_front());
        else step_cycle();
      end
    join
    while (u_chip.cap_q.size() < exp_tx.size()) step_cycle();
    repeat (8) step_cycle();

    assert (out_fifo_starved) else begin
      $display("FAIL %0t: out_fifo_starved low after all banks were sent", $time);
      errors++;
    end
    assert (u_chip.cap_q.size() == exp_tx.size()) else begin
      $display("FAIL %0t: chip captured %0d bytes, expected %0d", $time,
               u_chip.cap_q.size(), exp_tx.size());
      errors++;
    end
    for (int i = 0; i < exp_tx.size(); i++) begin
      assert (u_chip.cap_q[i] == exp_tx[i]) else begin
        $display("FAIL %0t: sent byte %0d is %h, expected %h", $time, i,
                 u_chip.cap_q[i], exp_tx[i]);
        errors++;
      end
    end

    $display("errors: %0d scoreboard, %0d protocol", errors, i_dut.u_props.fails);
    if (errors == 0 && i_dut.u_props.fails == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  // stimulus and limit are built at time zero
  initial begin
    #1;
    repeat (limit_cycles) @(posedge ftdi_clk);
    $display("timeout: traffic still running after %0d cycles", limit_cycles);
    $display("sim failed");
    $finish;
  end

endmodule

`default_nettype wire

/* ft_bridge_assertions.sv */
// protocol checks on the FT245 pins and FIFO flags
// bound into every ft_fifo_interface instance
`timescale 1ns/1ps
`default_nettype none

module ft_bridge_assertions (
  input wire       ftdi_clk,
  input wire       rst,
  input wire       ftdi_txe_n,
  input wire       ftdi_oe_n,
  input wire       ftdi_rd_n,
  input wire       ftdi_wr_n,
  input wire       in_fifo_ready,
  input wire [1:0] out_fifo_ready,
  input wire       out_fifo_starved
);

  // failure count for the closing report
  int fails = 0;

  task automatic log_failure(input string msg);
    $error("%s", msg);
    fails++;
  endtask

  assert property (@(posedge ftdi_clk) $fell(rst) |-> ftdi_oe_n && ftdi_rd_n && ftdi_wr_n &&
                   !in_fifo_ready && out_fifo_ready == 2'b11 && out_fifo_starved)
    else log_failure("pins or FIFO flags not idle right after reset");

  // chip full means no write strobe
  assert property (@(posedge ftdi_clk) disable iff (rst) !ftdi_wr_n |-> !ftdi_txe_n)
    else log_failure("wr_n low while txe_n is high");

  assert property (@(posedge ftdi_clk) disable iff (rst) !ftdi_rd_n |-> !ftdi_oe_n)
    else log_failure("rd_n low while oe_n is high");

  assert property (@(posedge ftdi_clk) disable iff (rst) !ftdi_wr_n |-> ftdi_oe_n)
    else log_failure("wr_n low while the chip drives the bus");

  assert property (@(posedge ftdi_clk) disable iff (rst) !(!ftdi_rd_n && !ftdi_wr_n))
    else log_failure("rd_n and wr_n low together");

endmodule

bind ft_fifo_interface ft_bridge_assertions u_props (.*);

`default_nettype wire

/* ft_chip_model.sv */
// behavioral FT245 chip for the bridge testbench
// host bytes leave host_q one burst at a time, bytes the bridge writes
// are collected in cap_q
`timescale 1ns/1ps
`default_nettype none

module ft_chip_model (
  input  wire       ftdi_clk,
  input  wire       rst,
  inout  wire [7:0] ftdi_data,
  output logic      ftdi_rxf_n,
  input  wire       ftdi_txe_n,
  input  wire       ftdi_oe_n,
  input  wire       ftdi_rd_n,
  input  wire       ftdi_wr_n
);

  logic [7:0] host_q [$];
  int         burst_q [$];
  logic [7:0] cap_q [$];
  int         burst_left = 0;
  logic [7:0] cur_byte = 8'h00;

  initial ftdi_rxf_n = 1'b1;

  // chip owns the bus only while oe_n is low
  assign ftdi_data = ftdi_oe_n ? 8'hzz : cur_byte;

  always @(posedge ftdi_clk) begin
    if (!rst) begin
      if (!ftdi_rd_n && !ftdi_oe_n && host_q.size() > 0) begin
        host_q.delete(0);
        burst_left--;
      end
      if (!ftdi_wr_n && !ftdi_txe_n) begin
        cap_q.push_back(ftdi_data);
      end
    end
    #1;
    // next burst only after rxf_n was high for a cycle
    if (!rst && burst_left == 0 && ftdi_rxf_n && burst_q.size() > 0) begin
      burst_left = burst_q.pop_front();
    end
    ftdi_rxf_n = (burst_left == 0);
    cur_byte   = (host_q.size() > 0) ? host_q[0] : 8'h00;
  end

endmodule

`default_nettype wire

/* ft_fifo_interface.sv */
// top level of the FT245 synchronous FIFO bridge
// host bytes land in the receive ping-pong FIFO, user bytes leave through
// the transmit ping-pong FIFO; both share the chip's data bus
`timescale 1ns/1ps
`default_nettype none

module ft_fifo_interface
  import ft_bridge_pkg::*;
(
  input  wire                    ftdi_clk,
  input  wire                    rst,

  // FTDI chip pins
  inout  wire [7:0]              ftdi_data,
  input  wire                    ftdi_rxf_n,
  input  wire                    ftdi_txe_n,
  output logic                   ftdi_oe_n,
  output logic                   ftdi_rd_n,
  output logic                   ftdi_wr_n,

  // host to user
  input  wire                    in_fifo_read,
  input  wire                    in_fifo_activate,
  output logic                   in_fifo_ready,
  output logic [COUNT_WIDTH-1:0] in_fifo_count,
  output rx_word_t               in_fifo_data,

  // user to host
  input  wire                    out_fifo_write,
  input  wire [1:0]              out_fifo_activate,
  output logic [1:0]             out_fifo_ready,
  output logic                   out_fifo_starved,
  input  wire [7:0]              out_fifo_data
);

  rx_word_t               rx_wr_data;
  logic [1:0]             rx_wr_ready;
  logic [1:0]             rx_wr_activate;
  logic                   rx_wr_strobe;

  logic                   tx_rd_ready;
  logic                   tx_rd_activate;
  logic                   tx_rd_strobe;
  logic [COUNT_WIDTH-1:0] tx_rd_count;
  logic [7:0]             tx_rd_data;

  logic                   rx_busy;
  logic                   tx_busy;
  logic [7:0]             tx_byte;

  // we drive the bus only while the chip's output is off
  assign ftdi_data = ftdi_oe_n ? tx_byte : 8'hzz;

  ppfifo #(.payload_t(rx_word_t)) rx_fifo (
    .ftdi_clk       (ftdi_clk),
    .rst            (rst),
    .write_data     (rx_wr_data),
    .write_ready    (rx_wr_ready),
    .write_activate (rx_wr_activate),
    .write_strobe   (rx_wr_strobe),
    .starved        (),
    .read_strobe    (in_fifo_read),
    .read_ready     (in_fifo_ready),
    .read_activate  (in_fifo_activate),
    .read_count     (in_fifo_count),
    .read_data      (in_fifo_data)
  );

  ppfifo #(.payload_t(logic [7:0])) tx_fifo (
    .ftdi_clk       (ftdi_clk),
    .rst            (rst),
    .write_data     (out_fifo_data),
    .write_ready    (out_fifo_ready),
    .write_activate (out_fifo_activate),
    .write_strobe   (out_fifo_write),
    .starved        (out_fifo_starved),
    .read_strobe    (tx_rd_strobe),
    .read_ready     (tx_rd_ready),
    .read_activate  (tx_rd_activate),
    .read_count     (tx_rd_count),
    .read_data      (tx_rd_data)
  );

  ft_rx_ctrl u_rx_ctrl (
    .ftdi_clk      (ftdi_clk),
    .rst           (rst),
    .rxf_n         (ftdi_rxf_n),
    .bus_data      (ftdi_data),
    .tx_busy       (tx_busy),
    .oe_n          (ftdi_oe_n),
    .rd_n          (ftdi_rd_n),
    .rx_busy       (rx_busy),
    .fifo_ready    (rx_wr_ready),
    .fifo_activate (rx_wr_activate),
    .fifo_strobe   (rx_wr_strobe),
    .fifo_data     (rx_wr_data)
  );

  ft_tx_ctrl u_tx_ctrl (
    .ftdi_clk      (ftdi_clk),
    .rst           (rst),
    .txe_n         (ftdi_txe_n),
    .rx_busy       (rx_busy),
    .wr_n          (ftdi_wr_n),
    .tx_busy       (tx_busy),
    .tx_byte       (tx_byte),
    .fifo_ready    (tx_rd_ready),
    .fifo_activate (tx_rd_activate),
    .fifo_count    (tx_rd_count),
    .fifo_data     (tx_rd_data),
    .fifo_strobe   (tx_rd_strobe)
  );

endmodule

`default_nettype wire

/* ft_tx_ctrl.sv */
// transmit side of the FT245 bridge
// takes a filled transmit bank and writes its bytes to the chip with
// wr_n whenever the chip has room and the receive side is off the bus
`timescale 1ns/1ps
`default_nettype none

module ft_tx_ctrl
  import ft_bridge_pkg::*;
(
  input  wire                   ftdi_clk,
  input  wire                   rst,

  // chip side
  input  wire                   txe_n,
  input  wire                   rx_busy,
  output logic                  wr_n,
  output logic                  tx_busy,
  output logic [7:0]            tx_byte,

  // transmit FIFO read side
  input  wire                   fifo_ready,
  output logic                  fifo_activate,
  input  wire [COUNT_WIDTH-1:0] fifo_count,
  input  wire [7:0]             fifo_data,
  output logic                  fifo_strobe
);

  tx_state_t              state;
  logic [COUNT_WIDTH-1:0] remain;

  assign tx_busy     = (state != tx_idle);

  // fifo strobe and wr_n pulse together, so a stalled byte stays put
  assign wr_n        = ~((state == tx_send) && !txe_n && !rx_busy && (remain != '0));
  assign fifo_strobe = ~wr_n;

  // fall-through word goes straight to the bus driver
  assign tx_byte     = fifo_data;

  always_ff @(posedge ftdi_clk) begin
    if (rst) begin
      state         <= tx_idle;
      fifo_activate <= 1'b0;
      remain        <= '0;
    end else begin
      case (state)
        tx_idle: begin
          if (fifo_ready) begin
            fifo_activate <= 1'b1;
            remain        <= fifo_count;
            state         <= tx_prepare;
          end
        end
        tx_prepare: begin
          state <= tx_send;
        end
        tx_send: begin
          if (remain == '0) begin
            fifo_activate <= 1'b0;
            state         <= tx_idle;
          end else if (fifo_strobe) begin
            remain <= remain - 1'b1;
          end
        end
        default: begin
          fifo_activate <= 1'b0;
          state         <= tx_idle;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* ft_rx_ctrl.sv */
// receive side of the FT245 bridge
// claims a free receive bank, turns the bus around with oe_n and reads
// host bytes with rd_n into the bank, tagging the first byte of a burst
`timescale 1ns/1ps
`default_nettype none

module ft_rx_ctrl
  import ft_bridge_pkg::*;
(
  input  wire         ftdi_clk,
  input  wire         rst,

  // chip side
  input  wire         rxf_n,
  input  wire [7:0]   bus_data,
  input  wire         tx_busy,
  output logic        oe_n,
  output logic        rd_n,
  output logic        rx_busy,

  // receive FIFO write side
  input  wire [1:0]   fifo_ready,
  output logic [1:0]  fifo_activate,
  output logic        fifo_strobe,
  output rx_word_t    fifo_data
);

  rx_state_t              state;
  logic [COUNT_WIDTH-1:0] space;
  logic                   avail_q;
  logic                   avail_rise;
  logic                   sof_pending;

  // bus belongs to the chip while we are turning around or reading
  assign rx_busy     = (state == rx_enable_output) || (state == rx_read);
  assign oe_n        = ~rx_busy;

  assign rd_n        = ~((state == rx_read) && !rxf_n && (space != '0));
  assign fifo_strobe = ~rd_n;

  assign avail_rise  = !rxf_n && !avail_q;
  assign fifo_data   = '{sof: sof_pending || avail_rise, data: bus_data};

  // start of frame tracking
  always_ff @(posedge ftdi_clk) begin
    if (rst) begin
      avail_q     <= 1'b0;
      sof_pending <= 1'b0;
    end else begin
      avail_q <= !rxf_n;
      // first stored byte consumes the tag
      if (fifo_strobe) begin
        sof_pending <= 1'b0;
      end else if (avail_rise) begin
        sof_pending <= 1'b1;
      end
    end
  end

  always_ff @(posedge ftdi_clk) begin
    if (rst) begin
      state         <= rx_idle;
      fifo_activate <= '0;
      space         <= '0;
    end else begin
      case (state)
        rx_idle: begin
          if (|fifo_ready) begin
            fifo_activate <= fifo_ready[0] ? 2'b01 : 2'b10;
            space         <= COUNT_WIDTH'(BANK_DEPTH);
            state         <= rx_wait_chip;
          end
        end
        rx_wait_chip: begin
          // never take the bus while a transmit is in flight
          if (!rxf_n && !tx_busy) begin
            state <= rx_enable_output;
          end
        end
        rx_enable_output: begin
          state <= rx_read;
        end
        rx_read: begin
          if (fifo_strobe) begin
            space <= space - 1'b1;
          end
          // chip ran dry or bank is full, hand the bank over
          if (rxf_n || (fifo_strobe && (space == COUNT_WIDTH'(1)))) begin
            fifo_activate <= '0;
            state         <= rx_idle;
          end
        end
        default: begin
          fifo_activate <= '0;
          state         <= rx_idle;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* ppfifo.sv */
// two-bank ping-pong FIFO on a single clock
// the writer claims an empty bank, fills it and releases it; the reader
// then drains the oldest filled bank with first-word fall-through
// payload_t sets the word type per instance
`timescale 1ns/1ps
`default_nettype none

module ppfifo
  import ft_bridge_pkg::*;
#(
  parameter type payload_t = logic [7:0]
) (
  input  wire                    ftdi_clk,
  input  wire                    rst,

  // write side
  input  wire payload_t          write_data,
  output logic [1:0]             write_ready,
  input  wire [1:0]              write_activate,
  input  wire                    write_strobe,
  output logic                   starved,

  // read side
  input  wire                    read_strobe,
  output logic                   read_ready,
  input  wire                    read_activate,
  output logic [COUNT_WIDTH-1:0] read_count,
  output payload_t               read_data
);

  payload_t                   mem [0:1][0:BANK_DEPTH-1];
  logic [COUNT_WIDTH-1:0]     count [0:1];

  // full_q marks a released bank that waits for or is under the reader
  logic [1:0]                 full_q;
  logic [1:0]                 act_q;
  logic [1:0]                 wr_en;
  logic [1:0]                 fill_done;

  // bank the reader takes next
  logic                       oldest;
  logic                       oldest_next;

  logic                       rd_busy;
  logic                       rd_start;
  logic                       rd_done;
  logic [BANK_ADDR_WIDTH-1:0] rd_ptr;

  always_comb begin
    for (int i = 0; i < 2; i++) begin
      wr_en[i]     = write_strobe && write_activate[i] && !full_q[i] &&
                     (count[i] != COUNT_WIDTH'(BANK_DEPTH));
      // falling activate with data hands the bank to the reader
      fill_done[i] = act_q[i] && !write_activate[i] && (count[i] != '0);
    end
  end

  // a bank stays unavailable for the cycle after its release
  assign write_ready = ~(full_q | write_activate | act_q);
  assign starved     = ~|(full_q | write_activate);

  assign rd_start    = read_activate && !rd_busy && full_q[oldest];
  assign rd_done     = rd_busy && !read_activate;
  assign read_ready  = full_q[oldest] && !rd_busy && !read_activate;
  assign read_count  = full_q[oldest] ? count[oldest] : '0;
  assign read_data   = mem[oldest][rd_ptr];

  always_comb begin
    oldest_next = oldest;
    if (rd_done) begin
      // move on only if the other bank has data or gets it now
      if (full_q[~oldest] || fill_done[~oldest]) begin
        oldest_next = ~oldest;
      end
    end else if (!full_q[oldest]) begin
      if (fill_done[0]) begin
        oldest_next = 1'b0;
      end else if (fill_done[1]) begin
        oldest_next = 1'b1;
      end
    end
  end

  always_ff @(posedge ftdi_clk) begin
    if (rst) begin
      for (int i = 0; i < 2; i++) begin
        count[i] <= '0;
      end
      full_q  <= '0;
      act_q   <= '0;
      oldest  <= 1'b0;
      rd_busy <= 1'b0;
      rd_ptr  <= '0;
    end else begin
      act_q  <= write_activate;
      oldest <= oldest_next;
      for (int i = 0; i < 2; i++) begin
        if (wr_en[i]) begin
          count[i] <= count[i] + 1'b1;
        end
        if (fill_done[i]) begin
          full_q[i] <= 1'b1;
        end
      end

      if (rd_start) begin
        rd_busy <= 1'b1;
      end
      // strobe may come together with the activate edge
      if (read_activate && read_strobe && (rd_busy || rd_start)) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (rd_done) begin
        rd_busy        <= 1'b0;
        rd_ptr         <= '0;
        full_q[oldest] <= 1'b0;
        count[oldest]  <= '0;
      end
    end
  end

  // bank storage
  always_ff @(posedge ftdi_clk) begin
    for (int i = 0; i < 2; i++) begin
      if (wr_en[i]) begin
        mem[i][count[i][BANK_ADDR_WIDTH-1:0]] <= write_data;
      end
    end
  end

endmodule

`default_nettype wire

/* ft_bridge_pkg.sv */
// shared constants and types for the FT245 synchronous FIFO bridge
// compile first, every design file imports it with a wildcard import
`default_nettype none

package ft_bridge_pkg;

  // one ping-pong bank holds 2**BANK_ADDR_WIDTH words
  localparam int BANK_ADDR_WIDTH = 4;
  localparam int BANK_DEPTH      = 1 << BANK_ADDR_WIDTH;

  // counts run from zero up to a full bank
  localparam int COUNT_WIDTH     = BANK_ADDR_WIDTH + 1;

  // byte from the host, tagged on the first byte of a burst
  typedef struct packed {
    logic       sof;
    logic [7:0] data;
  } rx_word_t;

  // receive controller
  typedef enum logic [1:0] {
    rx_idle          = 2'd0,
    rx_wait_chip     = 2'd1,
    rx_enable_output = 2'd2,
    rx_read          = 2'd3
  } rx_state_t;

  // transmit controller
  typedef enum logic [1:0] {
    tx_idle    = 2'd0,
    tx_prepare = 2'd1,
    tx_send    = 2'd2
  } tx_state_t;

endpackage

`default_nettype wire
